// File: Bender.yml
package:
  name: debug_renderer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/RenderPkg.sv
      - verilog/PixelScanner.sv
      - verilog/DebugCore.sv
      - verilog/FrameWriter.sv
      - verilog/DebugRenderer.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/DebugRendererTb.sv

// File: files.f
+incdir+include
verilog/RenderPkg.sv
verilog/PixelScanner.sv
verilog/DebugCore.sv
verilog/FrameWriter.sv
verilog/DebugRenderer.sv
tb/DebugRendererTb.sv

// File: include/render_config.svh
// Build-time settings of the debug shading path
// Screen size, bus widths and the checkerboard control bits

`ifndef RENDER_CONFIG_SVH
`define RENDER_CONFIG_SVH

// ---------------------------------------------------------------------------
// Screen
// ---------------------------------------------------------------------------

// Default frame size in pixels
`define RENDER_WIDTH 64
`define RENDER_HEIGHT 48

// ---------------------------------------------------------------------------
// Bus widths
// ---------------------------------------------------------------------------

// One pixel coordinate
`define RENDER_COORD_BITS 10

// Framebuffer word address
`define RENDER_ADDR_BITS 20

// ---------------------------------------------------------------------------
// Debug pattern
// ---------------------------------------------------------------------------

// Coordinate bit that picks the checker tile, so tiles are 16 pixels wide
`define RENDER_TILE_BIT 4

// Frame counter bit that swaps the palette, every 64 frames
`define RENDER_BLINK_BIT 6

`endif

// File: tb/DebugRendererTb.sv
// Testbench of the debug shading path
// Clock, reset, frame stimulus with random gaps and extra start pulses,
// a scoreboard model of the pixel walk and assertions against it

`timescale 1ns/10ps
`default_nettype none

`include "render_config.svh"

module DebugRendererTb;

    import RenderPkg::*;

    localparam int ScreenWidth  = 32;
    localparam int ScreenHeight = 16;
    localparam int PixelCount   = ScreenWidth * ScreenHeight;
    localparam int FrameTotal   = 70;
    localparam int FrameTimeout = 3 * PixelCount + 64;

    logic        clk;
    logic        resetn;
    logic        start;
    logic        fbWrite;
    fbAddr_t     fbAddr;
    rgb565_t     fbData;
    logic        frameDone;
    frameCount_t frameCounter;
    logic        busy;

    integer seed;
    int     valueErrors;
    int     protocolErrors;
    int     timeoutErrors;

    // Scoreboard state
    logic        modelActive;
    logic        awaitFirst;
    int          sinceEvent;
    int          acceptCount;
    int          expX;
    int          expY;
    frameCount_t expFrame;
    fbAddr_t     expAddr;
    rgb565_t     expData;
    logic        expLast;
    logic        expBusy;

    DebugRenderer #(
        .ScreenWidth (ScreenWidth),
        .ScreenHeight(ScreenHeight)
    ) DUT (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .fbWrite     (fbWrite),
        .fbAddr      (fbAddr),
        .fbData      (fbData),
        .frameDone   (frameDone),
        .frameCounter(frameCounter),
        .busy        (busy)
    );

    always #20 clk = ~clk;

    // Checkerboard word for one pixel, packed to RGB565
    function automatic rgb565_t checkerWord(input int x, input int y, input frameCount_t frame);
        logic       tileOdd;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        tileOdd = x[`RENDER_TILE_BIT] ^ y[`RENDER_TILE_BIT];
        if (frame[`RENDER_BLINK_BIT]) begin
            red   = tileOdd ? 8'hFF : 8'h00;
            green = tileOdd ? 8'h00 : 8'hFF;
            blue  = 8'h00;
        end else begin
            red   = tileOdd ? 8'hFF : 8'h00;
            green = 8'hFF;
            blue  = tileOdd ? 8'h00 : 8'hFF;
        end
        return {red[7:3], green[7:2], blue[7:3]};
    endfunction

    task automatic logValueError(input string msg);
        valueErrors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic logProtocolError(input string msg);
        protocolErrors++;
        $display("At time %0t: %s", $time, msg);
    endtask

    // Waits for frameDone while throwing in stray start pulses mid-frame
    task automatic waitFrameEnd(output bit finished);
        int cycles;
        finished = 1'b0;
        cycles   = 0;
        while (!finished && cycles < FrameTimeout) begin
            @(posedge clk);
            if (cycles < PixelCount && ($random(seed) & 15) == 0) begin
                start <= 1'b1;
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            if (frameDone) begin
                finished = 1'b1;
            end
            cycles++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Scoreboard model
    // ------------------------------------------------------------------------

    assign expAddr = fbAddr_t'(expY * ScreenWidth + expX);
    assign expData = checkerWord(expX, expY, expFrame);
    assign expLast = (expX == ScreenWidth - 1) && (expY == ScreenHeight - 1);

    // Core is busy in Render and Done, the two cycles before each write
    assign expBusy = modelActive && (sinceEvent >= (awaitFirst ? 2 : 1))
                     && (sinceEvent <= (awaitFirst ? 3 : 2));

    always @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            modelActive <= 1'b0;
            awaitFirst  <= 1'b0;
            sinceEvent  <= 0;
            acceptCount <= 0;
            expX        <= 0;
            expY        <= 0;
            expFrame    <= '0;
        end else begin
            if (fbWrite) begin
                if (expX == ScreenWidth - 1) begin
                    expX <= 0;
                    expY <= (expY == ScreenHeight - 1) ? 0 : expY + 1;
                end else begin
                    expX <= expX + 1;
                end
            end
            // The scanner is idle again in the frameDone cycle
            if (start && (!modelActive || frameDone)) begin
                modelActive <= 1'b1;
                awaitFirst  <= 1'b1;
                sinceEvent  <= 1;
                acceptCount <= acceptCount + 1;
                expX        <= 0;
                expY        <= 0;
            end else begin
                if (frameDone) begin
                    modelActive <= 1'b0;
                end
                if (fbWrite) begin
                    awaitFirst <= 1'b0;
                    sinceEvent <= 1;
                end else begin
                    sinceEvent <= sinceEvent + 1;
                end
            end
            if (frameDone) begin
                expFrame <= expFrame + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    idleBeforeStart: assert property (@(posedge clk) disable iff (!resetn)
        acceptCount == 0 |-> (!fbWrite && !frameDone && !busy && frameCounter == '0))
        else logValueError("outputs not idle before the first start");

    writeAddress: assert property (@(posedge clk) disable iff (!resetn)
        fbWrite |-> fbAddr == expAddr)
        else logValueError($sformatf("fbAddr %0d, expected %0d",
                                     $sampled(fbAddr), $sampled(expAddr)));

    writeData: assert property (@(posedge clk) disable iff (!resetn)
        fbWrite |-> fbData == expData)
        else logValueError($sformatf("fbData %h at address %0d, expected %h",
                                     $sampled(fbData), $sampled(expAddr), $sampled(expData)));

    doneAtLastWrite: assert property (@(posedge clk) disable iff (!resetn)
        fbWrite |-> frameDone == expLast)
        else logValueError($sformatf("frameDone %0b at address %0d",
                                     $sampled(frameDone), $sampled(expAddr)));

    doneWithWrite: assert property (@(posedge clk) disable iff (!resetn)
        frameDone |-> fbWrite)
        else logValueError("frameDone without a framebuffer write");

    counterStep: assert property (@(posedge clk) disable iff (!resetn)
        frameCounter == frameCount_t'(expFrame + frameDone))
        else logValueError($sformatf("frameCounter %0d, expected %0d",
                                     $sampled(frameCounter), $sampled(expFrame + frameDone)));

    writeSpacing: assert property (@(posedge clk) disable iff (!resetn)
        fbWrite |-> sinceEvent == (awaitFirst ? 4 : 3))
        else logValueError($sformatf("write came %0d cycles after the previous event",
                                     $sampled(sinceEvent)));

    writeMissing: assert property (@(posedge clk) disable iff (!resetn)
        (modelActive && !fbWrite) |-> sinceEvent < (awaitFirst ? 4 : 3))
        else logProtocolError("A framebuffer write is missing in a running frame");

    strayWrite: assert property (@(posedge clk) disable iff (!resetn)
        fbWrite |-> modelActive)
        else logProtocolError("The DUT wrote a pixel while no frame was running");

    busyWindow: assert property (@(posedge clk) disable iff (!resetn)
        busy == expBusy)
        else logValueError($sformatf("busy %0b, expected %0b",
                                     $sampled(busy), $sampled(expBusy)));

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial begin
        int gap;
        bit finished;
        clk            = 1'b0;
        resetn         = 1'b0;
        start          = 1'b0;
        seed           = 71625;
        valueErrors    = 0;
        protocolErrors = 0;
        timeoutErrors  = 0;

        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        // Quiet stretch before any start
        repeat (8) @(posedge clk);

        for (int frame = 0; frame < FrameTotal && timeoutErrors == 0; frame++) begin
            gap = $unsigned($random(seed)) % 6;
            repeat (gap) @(posedge clk);
            @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            waitFrameEnd(finished);
            if (!finished) begin
                timeoutErrors++;
                $display("Timeout: frame %0d did not finish within %0d cycles",
                         frame, FrameTimeout);
            end
        end

        @(posedge clk);
        start <= 1'b0;
        repeat (4) @(posedge clk);
        if (timeoutErrors == 0 && frameCounter != frameCount_t'(FrameTotal)) begin
            logValueError($sformatf("frameCounter ended at %0d, expected %0d",
                                    frameCounter, FrameTotal));
        end

        $display("Error counts: value %0d, protocol %0d, timeout %0d",
                 valueErrors, protocolErrors, timeoutErrors);
        if (valueErrors + protocolErrors + timeoutErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/DebugCore.sv
// Debug shading core
// Three-state FSM that replaces the real shader with a checkerboard
// whose palette flips with a bit of the frame counter

`timescale 1ns/10ps
`default_nettype none

`include "render_config.svh"

module DebugCore (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   addInput,
    input  RenderPkg::pixelCoord_t inputX,
    input  RenderPkg::pixelCoord_t inputY,
    input  RenderPkg::frameCount_t frameCounter,
    output logic                   fifoFull,
    output logic                   valid,
    output RenderPkg::pixelCoord_t shadeX,
    output RenderPkg::pixelCoord_t shadeY,
    output RenderPkg::rgb8_t       shadeColor
);

    import RenderPkg::*;

    debugCoreState_t state;

    pixelCoord_t latchedX;
    pixelCoord_t latchedY;
    logic        tileOdd;
    logic        blink;
    rgb8_t       tileColor;

    // ------------------------------------------------------------------------
    // Checkerboard color
    // ------------------------------------------------------------------------

    always_comb begin
        tileOdd = latchedX[`RENDER_TILE_BIT] ^ latchedY[`RENDER_TILE_BIT];
        blink   = frameCounter[`RENDER_BLINK_BIT];
        if (blink) begin
            // Red and green palette
            tileColor = tileOdd ? makeRgb8(8'd255, 8'd0, 8'd0)
                                : makeRgb8(8'd0, 8'd255, 8'd0);
        end else begin
            // Yellow and cyan palette
            tileColor = tileOdd ? makeRgb8(8'd255, 8'd255, 8'd0)
                                : makeRgb8(8'd0, 8'd255, 8'd255);
        end
    end

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= DCS_Init;
            fifoFull <= 1'b0;
            valid    <= 1'b0;
        end else begin
            case (state)
                DCS_Init: begin
                    if (addInput) begin
                        fifoFull <= 1'b1;
                        state    <= DCS_Render;
                    end
                end
                DCS_Render: begin
                    valid <= 1'b1;
                    state <= DCS_Done;
                end
                DCS_Done: begin
                    valid    <= 1'b0;
                    fifoFull <= 1'b0;
                    state    <= DCS_Init;
                end
                default: begin
                    valid    <= 1'b0;
                    fifoFull <= 1'b0;
                    state    <= DCS_Init;
                end
            endcase
        end
    end

    // Sample capture and shaded result
    always_ff @(posedge clk) begin
        if (state == DCS_Init && addInput) begin
            latchedX <= inputX;
            latchedY <= inputY;
        end
        if (state == DCS_Render) begin
            shadeX     <= latchedX;
            shadeY     <= latchedY;
            shadeColor <= tileColor;
        end
    end

    // A sample offered outside Init would be dropped
    assert property (@(posedge clk) disable iff (!resetn)
        addInput |-> (state == DCS_Init))
        else $error("DebugCore: addInput while a sample is still being shaded");

endmodule

`default_nettype wire

// File: verilog/DebugRenderer.sv
// Top of the debug shading path
// Pixel scanner feeding the debug core, whose results go to the
// framebuffer writer

`timescale 1ns/10ps
`default_nettype none

`include "render_config.svh"

module DebugRenderer #(
    parameter int ScreenWidth  = `RENDER_WIDTH,
    parameter int ScreenHeight = `RENDER_HEIGHT
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   start,
    output logic                   fbWrite,
    output RenderPkg::fbAddr_t     fbAddr,
    output RenderPkg::rgb565_t     fbData,
    output logic                   frameDone,
    output RenderPkg::frameCount_t frameCounter,
    output logic                   busy
);

    import RenderPkg::*;

    // Scanner to core
    logic        addInput;
    pixelCoord_t sampleX;
    pixelCoord_t sampleY;

    // Core to writer
    logic        shadeValid;
    pixelCoord_t shadeX;
    pixelCoord_t shadeY;
    rgb8_t       shadeColor;

    // ------------------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------------------

    PixelScanner #(
        .ScreenWidth (ScreenWidth),
        .ScreenHeight(ScreenHeight)
    ) scanner (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .shadeValid  (shadeValid),
        .addInput    (addInput),
        .sampleX     (sampleX),
        .sampleY     (sampleY),
        .frameCounter(frameCounter),
        .frameDone   (frameDone),
        // Busy is reported from the core, not the scanner
        .scanning    ()
    );

    DebugCore core (
        .clk         (clk),
        .resetn      (resetn),
        .addInput    (addInput),
        .inputX      (sampleX),
        .inputY      (sampleY),
        .frameCounter(frameCounter),
        .fifoFull    (busy),
        .valid       (shadeValid),
        .shadeX      (shadeX),
        .shadeY      (shadeY),
        .shadeColor  (shadeColor)
    );

    FrameWriter #(
        .ScreenWidth (ScreenWidth),
        .ScreenHeight(ScreenHeight)
    ) writer (
        .clk       (clk),
        .resetn    (resetn),
        .shadeValid(shadeValid),
        .shadeX    (shadeX),
        .shadeY    (shadeY),
        .shadeColor(shadeColor),
        .fbWrite   (fbWrite),
        .fbAddr    (fbAddr),
        .fbData    (fbData)
    );

endmodule

`default_nettype wire

// File: verilog/FrameWriter.sv
// Framebuffer write stage
// Linear address from the pixel position and RGB565 packing of the
// shaded color, registered with the write strobe

`timescale 1ns/10ps
`default_nettype none

`include "render_config.svh"

module FrameWriter #(
    parameter int ScreenWidth  = `RENDER_WIDTH,
    parameter int ScreenHeight = `RENDER_HEIGHT
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   shadeValid,
    input  RenderPkg::pixelCoord_t shadeX,
    input  RenderPkg::pixelCoord_t shadeY,
    input  RenderPkg::rgb8_t       shadeColor,
    output logic                   fbWrite,
    output RenderPkg::fbAddr_t     fbAddr,
    output RenderPkg::rgb565_t     fbData
);

    import RenderPkg::*;

    localparam fbAddr_t PixelCount = fbAddr_t'(ScreenWidth * ScreenHeight);

    fbAddr_t pixelAddr;
    rgb565_t packedColor;

    // ------------------------------------------------------------------------
    // Address and color
    // ------------------------------------------------------------------------

    // Row-major layout, one word per pixel
    assign pixelAddr = fbAddr_t'(shadeY) * fbAddr_t'(ScreenWidth) + fbAddr_t'(shadeX);

    // Keep the top bits of each channel
    assign packedColor = {shadeColor[23:19], shadeColor[15:10], shadeColor[7:3]};

    // ------------------------------------------------------------------------
    // Output registers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            fbWrite <= 1'b0;
        end else begin
            fbWrite <= shadeValid;
        end
    end

    always_ff @(posedge clk) begin
        if (shadeValid) begin
            fbAddr <= pixelAddr;
            fbData <= packedColor;
        end
    end

    // The scanner must never hand out a position outside the screen
    assert property (@(posedge clk) disable iff (!resetn)
        fbWrite |-> (fbAddr < PixelCount))
        else $error("FrameWriter: address %0d beyond the framebuffer", fbAddr);

endmodule

`default_nettype wire

// File: verilog/PixelScanner.sv
// Frame walker for the debug renderer
// Hands out one surface sample per finished shade in row-major order
// and counts completed frames

`timescale 1ns/10ps
`default_nettype none

`include "render_config.svh"

module PixelScanner #(
    parameter int ScreenWidth  = `RENDER_WIDTH,
    parameter int ScreenHeight = `RENDER_HEIGHT
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   start,
    input  logic                   shadeValid,
    output logic                   addInput,
    output RenderPkg::pixelCoord_t sampleX,
    output RenderPkg::pixelCoord_t sampleY,
    output RenderPkg::frameCount_t frameCounter,
    output logic                   frameDone,
    output logic                   scanning
);

    import RenderPkg::*;

    localparam pixelCoord_t LastX = pixelCoord_t'(ScreenWidth - 1);
    localparam pixelCoord_t LastY = pixelCoord_t'(ScreenHeight - 1);

    logic lastPixel;

    // Sample currently in the core is the bottom right corner
    assign lastPixel = (sampleX == LastX) && (sampleY == LastY);

    // ------------------------------------------------------------------------
    // Walk control
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            scanning     <= 1'b0;
            addInput     <= 1'b0;
            frameDone    <= 1'b0;
            sampleX      <= '0;
            sampleY      <= '0;
            frameCounter <= '0;
        end else begin
            addInput  <= 1'b0;
            frameDone <= 1'b0;
            if (!scanning) begin
                // start is only honored between frames
                if (start) begin
                    scanning <= 1'b1;
                    addInput <= 1'b1;
                    sampleX  <= '0;
                    sampleY  <= '0;
                end
            end else if (shadeValid) begin
                if (lastPixel) begin
                    scanning     <= 1'b0;
                    frameDone    <= 1'b1;
                    frameCounter <= frameCounter + 1'b1;
                end else begin
                    addInput <= 1'b1;
                    if (sampleX == LastX) begin
                        sampleX <= '0;
                        sampleY <= sampleY + 1'b1;
                    end else begin
                        sampleX <= sampleX + 1'b1;
                    end
                end
            end
        end
    end

    // One sample in flight at a time, the core answers before the next one
    assert property (@(posedge clk) disable iff (!resetn)
        addInput |=> (!addInput until_with shadeValid))
        else $error("PixelScanner: addInput issued while a sample is outstanding");

endmodule

`default_nettype wire

// File: verilog/RenderPkg.sv
// Shared types of the debug shading path
// Coordinate, color, address and frame count vectors, core FSM states
// and a helper that builds a 24-bit color

`default_nettype none

`include "render_config.svh"

package RenderPkg;

    // -----------------------------------------------------------------------
    // Vector types
    // -----------------------------------------------------------------------

    // One screen coordinate
    typedef logic [`RENDER_COORD_BITS-1:0] pixelCoord_t;

    // Red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] rgb8_t;

    // Framebuffer color, 5 bits red, 6 green, 5 blue
    typedef logic [15:0] rgb565_t;

    // Framebuffer word address
    typedef logic [`RENDER_ADDR_BITS-1:0] fbAddr_t;

    typedef logic [15:0] frameCount_t;

    // -----------------------------------------------------------------------
    // Debug core FSM
    // -----------------------------------------------------------------------

    typedef enum logic [1:0] {
        DCS_Init,
        DCS_Render,
        DCS_Done
    } debugCoreState_t;

    // Pack three channel bytes into one color word
    function automatic rgb8_t makeRgb8(
        input logic [7:0] red,
        input logic [7:0] green,
        input logic [7:0] blue
    );
        return {red, green, blue};
    endfunction

endpackage

`default_nettype wire
